// File: rtl/isaPkg.sv
/*
 * instruction set constants, opcode values and the two views of an instruction word
 */
package isaPkg;

	localparam int xlen = 32;
	localparam int regIdWidth = 4;
	localparam int opcodeWidth = 6;
	localparam int immWidth = 18;

	localparam logic [regIdWidth-1:0] zeroReg = '0;	// always reads zero

	localparam logic [opcodeWidth-1:0] opNop = 6'd0;
	localparam logic [opcodeWidth-1:0] opAdd = 6'd1;
	localparam logic [opcodeWidth-1:0] opSub = 6'd2;
	localparam logic [opcodeWidth-1:0] opAnd = 6'd3;
	localparam logic [opcodeWidth-1:0] opOr = 6'd4;
	localparam logic [opcodeWidth-1:0] opXor = 6'd5;
	localparam logic [opcodeWidth-1:0] opAddi = 6'd6;
	localparam logic [opcodeWidth-1:0] opMul = 6'd7;	// low half of product
	localparam logic [opcodeWidth-1:0] opMulh = 6'd8;	// high half of product
	localparam logic [opcodeWidth-1:0] opBra = 6'd9;
	localparam logic [opcodeWidth-1:0] opBrz = 6'd10;

	// three register operands
	typedef struct packed {
		logic [opcodeWidth-1:0] opcode;
		logic [regIdWidth-1:0] rn;
		logic [regIdWidth-1:0] rm;
		logic [regIdWidth-1:0] ro;
		logic [13:0] spare;
	} regFormWord;

	// two registers plus signed immediate
	typedef struct packed {
		logic [opcodeWidth-1:0] opcode;
		logic [regIdWidth-1:0] rn;
		logic [regIdWidth-1:0] rm;
		logic [immWidth-1:0] imm;
	} immFormWord;

	typedef union packed {
		regFormWord regForm;
		immFormWord immForm;
	} instrWord;

endpackage

// File: rtl/pipePkg.sv
/*
 * pipeline constants: reset pc, pc step, branch offset scaling
 */
package pipePkg;

	// first fetch address
	localparam logic [isaPkg::xlen-1:0] resetPc = '0;

	// bytes per instruction
	localparam logic [isaPkg::xlen-1:0] pcStep = 4;

	// branch imm counts instructions, not bytes
	localparam int branchShift = 2;

endpackage

// File: rtl/issueIf.sv
/*
 * issue bundle from the operand stage into EX1
 */
`timescale 1ns/1ps

interface issueIf;

	logic valid;	// low for a bubble
	logic writes;	// valid and dest is not the zero register
	logic [isaPkg::opcodeWidth-1:0] opcode;
	logic [isaPkg::regIdWidth-1:0] dest;
	logic [isaPkg::xlen-1:0] valA;
	logic [isaPkg::xlen-1:0] valB;	// immediate for ADDI
	logic [isaPkg::xlen-1:0] pc;
	logic [isaPkg::xlen-1:0] imm;	// sign extended

	modport issue (
		output valid, writes, opcode, dest, valA, valB, pc, imm
	);

	modport exec (
		input valid, writes, opcode, dest, valA, valB, pc, imm
	);

endinterface

// File: rtl/fetchUnit.sv
/*
 * program counter with interlock hold and branch redirect
 */
`timescale 1ns/1ps

module fetchUnit (
	input logic clock,
	input logic reset,
	input logic hold,
	input logic branchTaken,
	input logic [isaPkg::xlen-1:0] branchTarget,
	output logic [isaPkg::xlen-1:0] pc
);

	always_ff @(posedge clock)
	begin
		if (reset)
			pc <= pipePkg::resetPc;
		else if (branchTaken)	// wins over hold
			pc <= branchTarget;
		else if (!hold)
			pc <= pc + pipePkg::pcStep;
	end

endmodule

// File: rtl/regFile.sv
/*
 * sixteen general registers, two read ports with write-through, one write port
 */
`timescale 1ns/1ps

module regFile (
	input logic clock,
	input logic [isaPkg::regIdWidth-1:0] readIdA,
	input logic [isaPkg::regIdWidth-1:0] readIdB,
	output logic [isaPkg::xlen-1:0] readValA,
	output logic [isaPkg::xlen-1:0] readValB,
	input logic writeEnable,
	input logic [isaPkg::regIdWidth-1:0] writeId,
	input logic [isaPkg::xlen-1:0] writeVal
);

	logic [isaPkg::xlen-1:0] regs [2**isaPkg::regIdWidth];

	// R0 first, then a same-cycle write, then the array
	function automatic logic [isaPkg::xlen-1:0] readPort(
		input logic [isaPkg::regIdWidth-1:0] id
	);
		logic [isaPkg::xlen-1:0] value;
		if (id == isaPkg::zeroReg)
			value = '0;
		else if (writeEnable && writeId == id)
			value = writeVal;	// EX2 producer, saves a stall
		else
			value = regs[id];
		return value;
	endfunction

	always_comb
	begin
		readValA = readPort(readIdA);
		readValB = readPort(readIdB);
	end

	always_ff @(posedge clock)
	begin
		if (writeEnable && writeId != isaPkg::zeroReg)	// R0 writes dropped
			regs[writeId] <= writeVal;
	end

endmodule

// File: rtl/decodeStage.sv
/*
 * ID and operand-read stages, source interlock against EX1, issue register into EX1
 */
`timescale 1ns/1ps

module decodeStage (
	input logic clock,
	input logic reset,
	input logic [isaPkg::xlen-1:0] pc,
	input isaPkg::instrWord instrData,
	input logic branchTaken,
	output logic hold,
	output logic [isaPkg::regIdWidth-1:0] readIdA,
	output logic [isaPkg::regIdWidth-1:0] readIdB,
	input logic [isaPkg::xlen-1:0] readValA,
	input logic [isaPkg::xlen-1:0] readValB,
	issueIf.issue issue
);

	// ID register
	logic idValid;
	isaPkg::instrWord idWord;
	logic [isaPkg::xlen-1:0] idPc;

	// decoded from idWord
	logic [isaPkg::opcodeWidth-1:0] decOp;
	logic decWrites;
	logic decUseA;
	logic decUseB;
	logic decImmSel;
	logic [isaPkg::xlen-1:0] decImm;

	// operand stage
	logic opValid;
	logic [isaPkg::opcodeWidth-1:0] opCode;
	logic [isaPkg::regIdWidth-1:0] opDest;
	logic [isaPkg::regIdWidth-1:0] opSrcA;
	logic [isaPkg::regIdWidth-1:0] opSrcB;
	logic opUseA;
	logic opUseB;
	logic opWrites;
	logic opImmSel;
	logic [isaPkg::xlen-1:0] opImm;
	logic [isaPkg::xlen-1:0] opPc;

	always_ff @(posedge clock)
	begin
		if (reset || branchTaken)
			idValid <= 1'b0;
		else if (!hold)
			idValid <= 1'b1;
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			idWord <= instrData;
			idPc <= pc;
		end
	end

	always_comb
	begin
		decOp = isaPkg::opNop;	// unknown opcodes fall through as NOP
		decWrites = 1'b0;
		decUseA = 1'b0;
		decUseB = 1'b0;
		decImmSel = 1'b0;
		case (idWord.regForm.opcode)
			isaPkg::opAdd, isaPkg::opSub, isaPkg::opAnd, isaPkg::opOr, isaPkg::opXor,
			isaPkg::opMul, isaPkg::opMulh:
			begin
				decOp = idWord.regForm.opcode;
				decWrites = 1'b1;
				decUseA = 1'b1;
				decUseB = 1'b1;
			end
			isaPkg::opAddi:
			begin
				decOp = isaPkg::opAddi;
				decWrites = 1'b1;
				decUseA = 1'b1;
				decImmSel = 1'b1;	// ro field is part of imm here
			end
			isaPkg::opBra:
				decOp = isaPkg::opBra;
			isaPkg::opBrz:
			begin
				decOp = isaPkg::opBrz;
				decUseA = 1'b1;	// tested against zero
			end
			default:
				decOp = isaPkg::opNop;
		endcase
		if (idWord.regForm.rn == isaPkg::zeroReg)
			decWrites = 1'b0;
		decImm = {{(isaPkg::xlen - isaPkg::immWidth){idWord.immForm.imm[isaPkg::immWidth-1]}},
			idWord.immForm.imm};
	end

	always_ff @(posedge clock)
	begin
		if (reset || branchTaken)
			opValid <= 1'b0;
		else if (!hold)
			opValid <= idValid;
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			opCode <= decOp;
			opDest <= idWord.regForm.rn;
			opSrcA <= idWord.regForm.rm;
			opSrcB <= idWord.regForm.ro;
			opUseA <= decUseA;
			opUseB <= decUseB;
			opWrites <= decWrites;
			opImmSel <= decImmSel;
			opImm <= decImm;
			opPc <= idPc;
		end
	end

	assign readIdA = opSrcA;
	assign readIdB = opSrcB;

	// source still being produced in EX1, EX2 is covered by write-through
	assign hold = opValid && issue.writes &&
		((opUseA && opSrcA == issue.dest) || (opUseB && opSrcB == issue.dest));

	always_ff @(posedge clock)
	begin
		if (reset || branchTaken || hold)
		begin
			issue.valid <= 1'b0;	// bubble
			issue.writes <= 1'b0;
		end
		else
		begin
			issue.valid <= opValid;
			issue.writes <= opValid && opWrites;
		end
	end

	always_ff @(posedge clock)
	begin
		issue.opcode <= opCode;
		issue.dest <= opDest;
		issue.valA <= readValA;
		issue.valB <= opImmSel ? opImm : readValB;
		issue.pc <= opPc;
		issue.imm <= opImm;
	end

endmodule

// File: rtl/aluUnit.sv
/*
 * EX1 arithmetic and logic, branch resolution, result register into EX2
 */
`timescale 1ns/1ps

module aluUnit (
	input logic clock,
	input logic reset,
	issueIf.exec issue,
	output logic branchTaken,
	output logic [isaPkg::xlen-1:0] branchTarget,
	output logic [isaPkg::xlen-1:0] aluResult
);

	logic [isaPkg::xlen-1:0] aluNext;

	always_comb
	begin
		case (issue.opcode)
			isaPkg::opAdd, isaPkg::opAddi:
				aluNext = issue.valA + issue.valB;	// valB carries imm for ADDI
			isaPkg::opSub:
				aluNext = issue.valA - issue.valB;
			isaPkg::opAnd:
				aluNext = issue.valA & issue.valB;
			isaPkg::opOr:
				aluNext = issue.valA | issue.valB;
			isaPkg::opXor:
				aluNext = issue.valA ^ issue.valB;
			default:
				aluNext = '0;
		endcase
	end

	// redirect straight from EX1, younger stages get killed
	assign branchTaken = issue.valid &&
		(issue.opcode == isaPkg::opBra ||
		(issue.opcode == isaPkg::opBrz && issue.valA == '0));
	assign branchTarget = issue.pc + (issue.imm << pipePkg::branchShift);

	always_ff @(posedge clock)
	begin
		if (reset)
			aluResult <= '0;
		else if (issue.valid)
			aluResult <= aluNext;
	end

endmodule

// File: rtl/mulUnit.sv
/*
 * EX1 unsigned multiplier with the low or high product half registered into EX2
 */
`timescale 1ns/1ps

module mulUnit (
	input logic clock,
	issueIf.exec issue,
	output logic [isaPkg::xlen-1:0] mulResult
);

	logic [2*isaPkg::xlen-1:0] product;

	// both operands zero-extended to the full product width
	assign product = {{isaPkg::xlen{1'b0}}, issue.valA} * {{isaPkg::xlen{1'b0}}, issue.valB};

	always_ff @(posedge clock)
	begin
		if (issue.opcode == isaPkg::opMulh)
			mulResult <= product[2*isaPkg::xlen-1:isaPkg::xlen];
		else
			mulResult <= product[isaPkg::xlen-1:0];
	end

endmodule

// File: rtl/writebackStage.sv
/*
 * EX2 result select between ALU and multiplier, register file write port
 */
`timescale 1ns/1ps

module writebackStage (
	input logic clock,
	input logic reset,
	issueIf.exec issue,
	input logic [isaPkg::xlen-1:0] aluResult,
	input logic [isaPkg::xlen-1:0] mulResult,
	output logic writeEnable,
	output logic [isaPkg::regIdWidth-1:0] writeId,
	output logic [isaPkg::xlen-1:0] writeVal
);

	logic ex2Writes;
	logic [isaPkg::regIdWidth-1:0] ex2Dest;
	logic ex2IsMul;	// picks the multiplier result

	always_ff @(posedge clock)
	begin
		if (reset)
			ex2Writes <= 1'b0;
		else
			ex2Writes <= issue.writes;
	end

	always_ff @(posedge clock)
	begin
		ex2Dest <= issue.dest;
		ex2IsMul <= (issue.opcode == isaPkg::opMul) || (issue.opcode == isaPkg::opMulh);
	end

	assign writeEnable = ex2Writes;	// also the core's wbValid
	assign writeId = ex2Dest;
	assign writeVal = ex2IsMul ? mulResult : aluResult;

endmodule

// File: rtl/coreTop.sv
/*
 * core top level: fetch, decode, register file, ALU, multiplier and writeback
 */
`timescale 1ns/1ps

module coreTop (
	input logic clock,
	input logic reset,
	output logic [31:0] instrAddr,
	input logic [31:0] instrData,
	output logic wbValid,
	output logic [3:0] wbReg,
	output logic [31:0] wbValue
);

	logic [isaPkg::xlen-1:0] pc;
	logic hold;
	logic branchTaken;
	logic [isaPkg::xlen-1:0] branchTarget;
	logic [isaPkg::regIdWidth-1:0] readIdA;
	logic [isaPkg::regIdWidth-1:0] readIdB;
	logic [isaPkg::xlen-1:0] readValA;
	logic [isaPkg::xlen-1:0] readValB;
	logic [isaPkg::xlen-1:0] aluResult;
	logic [isaPkg::xlen-1:0] mulResult;
	logic writeEnable;
	logic [isaPkg::regIdWidth-1:0] writeId;
	logic [isaPkg::xlen-1:0] writeVal;

	issueIf i_issueIf ();	// operand stage to EX1

	fetchUnit i_fetchUnit (
		.clock(clock),
		.reset(reset),
		.hold(hold),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.pc(pc)
	);

	decodeStage i_decodeStage (
		.clock(clock),
		.reset(reset),
		.pc(pc),
		.instrData(instrData),
		.branchTaken(branchTaken),
		.hold(hold),
		.readIdA(readIdA),
		.readIdB(readIdB),
		.readValA(readValA),
		.readValB(readValB),
		.issue(i_issueIf)
	);

	regFile i_regFile (
		.clock(clock),
		.readIdA(readIdA),
		.readIdB(readIdB),
		.readValA(readValA),
		.readValB(readValB),
		.writeEnable(writeEnable),
		.writeId(writeId),
		.writeVal(writeVal)
	);

	aluUnit i_aluUnit (
		.clock(clock),
		.reset(reset),
		.issue(i_issueIf),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.aluResult(aluResult)
	);

	mulUnit i_mulUnit (
		.clock(clock),
		.issue(i_issueIf),
		.mulResult(mulResult)
	);

	writebackStage i_writebackStage (
		.clock(clock),
		.reset(reset),
		.issue(i_issueIf),
		.aluResult(aluResult),
		.mulResult(mulResult),
		.writeEnable(writeEnable),
		.writeId(writeId),
		.writeVal(writeVal)
	);

	assign instrAddr = pc;
	assign wbValid = writeEnable;
	assign wbReg = writeId;
	assign wbValue = writeVal;

endmodule

// File: verification/coreTb.sv
/*
 * testbench for coreTop with program ROM, reference model and assertion checks,
 * clock, reset and watchdog
 */
`timescale 1ns/1ps

module coreTb;

	localparam int halfPeriod = 50;
	localparam int resetCycles = 10;
	localparam int driveDelay = 10;	// after the rising edge
	localparam int drainCycles = 20;
	localparam int romDepth = 64;
	localparam int maxExp = 128;

	logic clock;
	logic reset;
	logic [31:0] instrAddr;
	logic [31:0] instrData;
	logic wbValid;
	logic [3:0] wbReg;
	logic [31:0] wbValue;

	isaPkg::instrWord rom [romDepth];
	int progSize;
	logic [31:0] lcgState;

	// model writebacks in program order
	logic [3:0] expRegs [maxExp];
	logic [31:0] expVals [maxExp];
	int expCount = 0;
	int wbCount = 0;
	int cycleCount = 0;
	int errorCount = 0;
	logic expAvail;
	logic [3:0] expReg;
	logic [31:0] expVal;

	coreTop i_coreTop (
		.clock(clock),
		.reset(reset),
		.instrAddr(instrAddr),
		.instrData(instrData),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbValue(wbValue)
	);

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// sign bit chosen by the caller and the rest random
	function automatic logic [17:0] randomImm(input logic negative);
		logic [31:0] r;
		r = nextRandom();
		return {negative, r[26:10]};
	endfunction

	function automatic isaPkg::instrWord encodeReg(input logic [5:0] op,
		input logic [3:0] rn, input logic [3:0] rm, input logic [3:0] ro);
		isaPkg::instrWord word;
		word.regForm.opcode = op;
		word.regForm.rn = rn;
		word.regForm.rm = rm;
		word.regForm.ro = ro;
		word.regForm.spare = '0;
		return word;
	endfunction

	function automatic isaPkg::instrWord encodeImm(input logic [5:0] op,
		input logic [3:0] rn, input logic [3:0] rm, input logic [17:0] imm);
		isaPkg::instrWord word;
		word.immForm.opcode = op;
		word.immForm.rn = rn;
		word.immForm.rm = rm;
		word.immForm.imm = imm;
		return word;
	endfunction

	task automatic appendInstr(input isaPkg::instrWord word);
		rom[progSize] = word;
		progSize++;
	endtask

	task automatic buildProgram();
		for (int i = 0; i < romDepth; i++)
			rom[i] = {6'h3F, 4'(i), 22'(i)};	// unknown opcode that is never reached
		progSize = 0;
		appendInstr(encodeImm(isaPkg::opAddi, 4'd1, 4'd0, randomImm(1'b1)));
		appendInstr(encodeImm(isaPkg::opAddi, 4'd2, 4'd0, randomImm(1'b0)));
		appendInstr(encodeImm(isaPkg::opAddi, 4'd3, 4'd0, randomImm(1'b1)));
		appendInstr(encodeReg(isaPkg::opAdd, 4'd4, 4'd1, 4'd2));
		appendInstr(encodeReg(isaPkg::opSub, 4'd5, 4'd4, 4'd3));	// chain of EX1 producers
		appendInstr(encodeReg(isaPkg::opAnd, 4'd6, 4'd5, 4'd1));
		appendInstr(encodeReg(isaPkg::opOr, 4'd7, 4'd6, 4'd2));
		appendInstr(encodeReg(isaPkg::opXor, 4'd8, 4'd7, 4'd3));
		appendInstr(encodeImm(isaPkg::opAddi, 4'd9, 4'd8, randomImm(1'b1)));
		appendInstr(encodeReg(isaPkg::opMul, 4'd10, 4'd1, 4'd3));
		appendInstr(encodeReg(isaPkg::opMulh, 4'd11, 4'd1, 4'd3));
		appendInstr(encodeReg(isaPkg::opMul, 4'd12, 4'd10, 4'd9));
		appendInstr(encodeReg(isaPkg::opMulh, 4'd13, 4'd11, 4'd2));
		appendInstr(encodeImm(isaPkg::opAddi, 4'd0, 4'd5, randomImm(1'b0)));	// R0 write
		appendInstr(encodeReg(isaPkg::opAdd, 4'd14, 4'd0, 4'd6));
		appendInstr(encodeReg(isaPkg::opNop, 4'd7, 4'd1, 4'd2));
		appendInstr(encodeReg(6'h3E, 4'd5, 4'd1, 4'd2));	// unknown opcode
		appendInstr(encodeReg(isaPkg::opAdd, 4'd15, 4'd0, 4'd0));
		appendInstr(encodeImm(isaPkg::opBrz, 4'd0, 4'd15, 18'd5));	// taken
		appendInstr(encodeImm(isaPkg::opAddi, 4'd1, 4'd0, 18'd1));
		appendInstr(encodeImm(isaPkg::opAddi, 4'd2, 4'd0, 18'd2));
		appendInstr(encodeImm(isaPkg::opAddi, 4'd3, 4'd0, 18'd3));
		appendInstr(encodeImm(isaPkg::opAddi, 4'd4, 4'd0, 18'd4));
		appendInstr(encodeImm(isaPkg::opBrz, 4'd0, 4'd1, 18'd10));	// R1 is negative so not taken
		appendInstr(encodeImm(isaPkg::opAddi, 4'd4, 4'd4, randomImm(1'b1)));
		appendInstr(encodeImm(isaPkg::opBra, 4'd0, 4'd0, 18'd4));
		appendInstr(encodeImm(isaPkg::opAddi, 4'd5, 4'd0, 18'd5));
		appendInstr(encodeImm(isaPkg::opAddi, 4'd6, 4'd0, 18'd6));
		appendInstr(encodeImm(isaPkg::opAddi, 4'd7, 4'd0, 18'd7));
		appendInstr(encodeReg(isaPkg::opSub, 4'd8, 4'd4, 4'd9));
		appendInstr(encodeReg(isaPkg::opMulh, 4'd9, 4'd8, 4'd8));
		appendInstr(encodeReg(isaPkg::opXor, 4'd10, 4'd9, 4'd4));
		appendInstr(encodeReg(isaPkg::opMul, 4'd11, 4'd10, 4'd10));
		appendInstr(encodeImm(isaPkg::opBra, 4'd0, 4'd0, 18'd0));	// parks here
	endtask

	// walks the program in order and stops at a branch to itself
	task automatic runReferenceModel();
		logic [31:0] regs [16];
		isaPkg::instrWord w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] result;
		logic [63:0] product;
		logic writes;
		int idx;
		int nextIdx;
		foreach (regs[i])
			regs[i] = '0;
		idx = 0;
		expCount = 0;
		for (int step = 0; step < 500; step++)
		begin
			w = rom[idx];
			imm = {{14{w.immForm.imm[17]}}, w.immForm.imm};
			a = regs[w.regForm.rm];
			b = (w.regForm.opcode == isaPkg::opAddi) ? imm : regs[w.regForm.ro];
			product = {32'd0, a} * {32'd0, b};
			writes = 1'b1;
			result = '0;
			nextIdx = idx + 1;
			case (w.regForm.opcode)
				isaPkg::opAdd, isaPkg::opAddi:
					result = a + b;
				isaPkg::opSub:
					result = a - b;
				isaPkg::opAnd:
					result = a & b;
				isaPkg::opOr:
					result = a | b;
				isaPkg::opXor:
					result = a ^ b;
				isaPkg::opMul:
					result = product[31:0];
				isaPkg::opMulh:
					result = product[63:32];
				isaPkg::opBra:
				begin
					writes = 1'b0;
					nextIdx = idx + int'($signed(imm));	// imm counts instructions
				end
				isaPkg::opBrz:
				begin
					writes = 1'b0;
					if (a == '0)
						nextIdx = idx + int'($signed(imm));
				end
				default:
					writes = 1'b0;	// NOP and unknown
			endcase
			if (writes && w.regForm.rn != 4'd0)
			begin
				regs[w.regForm.rn] = result;
				expRegs[expCount] = w.regForm.rn;
				expVals[expCount] = result;
				expCount++;
			end
			if (nextIdx == idx)
				break;
			idx = nextIdx;
		end
	endtask

	task automatic reportMismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
		errorCount++;
	endtask

	task automatic reportFailure(input string what);
		$display("Failure at %0t: %s", $time, what);
		errorCount++;
	endtask

	task automatic printSummary();
		$display("summary: %0d errors, %0d of %0d writebacks seen",
			errorCount, wbCount, expCount);
	endtask

	// ROM answers the fetch address directly
	always_comb
	begin
		if (instrAddr < romDepth * 4)
			instrData = rom[instrAddr[7:2]];
		else
			instrData = '0;
	end

	always @(posedge clock)
	begin
		cycleCount <= cycleCount + 1;
		if (reset)
			wbCount <= 0;
		else if (wbValid)
			wbCount <= wbCount + 1;
	end

	assign expAvail = wbCount < expCount;
	assign expReg = expRegs[wbCount[6:0]];
	assign expVal = expVals[wbCount[6:0]];

	noWbInReset: assert property (@(posedge clock) reset && cycleCount > 0 |-> !wbValid)
		else reportFailure("wbValid went high while reset was asserted");

	firstFetch: assert property (@(posedge clock) $fell(reset) |-> instrAddr == pipePkg::resetPc)
		else reportMismatch("instrAddr", pipePkg::resetPc, $sampled(instrAddr));

	firstWriteback: assert property (@(posedge clock)
		$fell(reset) |-> !wbValid ##1 !wbValid ##1 !wbValid ##1 !wbValid ##1 wbValid)
		else reportFailure("first instruction did not write back exactly 4 cycles after reset");

	noZeroRegWrite: assert property (@(posedge clock) wbValid |-> wbReg != isaPkg::zeroReg)
		else reportFailure("a write to R0 showed up as a writeback");

	noExtraWriteback: assert property (@(posedge clock) wbValid |-> expAvail)
		else reportFailure("writeback beyond the end of the expected sequence");

	wbRegCheck: assert property (@(posedge clock) wbValid && expAvail |-> wbReg == expReg)
		else reportMismatch("wbReg", 32'($sampled(expReg)), 32'($sampled(wbReg)));

	wbValueCheck: assert property (@(posedge clock) wbValid && expAvail |-> wbValue == expVal)
		else reportMismatch("wbValue", $sampled(expVal), $sampled(wbValue));

	initial
	begin
		clock = 1'b0;
		forever
			#halfPeriod clock = ~clock;
	end

	initial
	begin
		reset = 1'b1;
		lcgState = 32'd91;
		buildProgram();
		runReferenceModel();
		repeat (resetCycles) @(posedge clock);
		#driveDelay;
		reset = 1'b0;
		while (wbCount < expCount)
			@(negedge clock);
		repeat (drainCycles) @(posedge clock);	// parked branch must stay quiet
		printSummary();
		if (errorCount == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	// four cycles per instruction plus margin
	initial
	begin
		@(negedge reset);
		repeat (progSize * 4 + 100) @(posedge clock);
		$display("watchdog expired before all expected writebacks arrived");
		printSummary();
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: src.f
rtl/isaPkg.sv
rtl/pipePkg.sv
rtl/issueIf.sv
rtl/fetchUnit.sv
rtl/regFile.sv
rtl/decodeStage.sv
rtl/aluUnit.sv
rtl/mulUnit.sv
rtl/writebackStage.sv
rtl/coreTop.sv
verification/coreTb.sv

// File: Makefile
TOP = coreTb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert --top-module coreTop -f src.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f src.f \
		-Mdir obj_dir -o simv
	@out="$$(./obj_dir/simv)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
